/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f mipsFrontEnd.f --top-module mipsFrontEndBench -o simBench

run: build
	./obj_dir/simBench > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing -f mipsFrontEnd.f --top-module mipsFrontEnd

clean:
	rm -rf obj_dir sim.log

/* bench/instrMemory.sv */
`timescale 1ns/1ps

// read-only Wishbone classic slave holding the program
module instrMemory (
	input logic clk,
	input logic rst,
	input mipsPkg::word_t adr,
	input logic cyc,
	input logic stb,
	input logic we,
	output mipsPkg::word_t datOut,
	output logic ack,
	// extra wait cycles before ack, may change between requests
	input logic [1:0] waitCycles
);
	// 256 words, wraps on address bits 9:2
	mipsPkg::word_t prog [0:255];
	logic [1:0] count;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
			count <= 2'd0;
			datOut <= 32'd0;
		end else if (ack) begin
			// master drops cyc on this edge
			ack <= 1'b0;
			count <= 2'd0;
		end else if (cyc && stb && !we) begin
			if (count >= waitCycles) begin
				ack <= 1'b1;
				datOut <= prog[adr[9:2]];
				count <= 2'd0;
			end else begin
				count <= count + 2'd1;
			end
		end
	end
endmodule

/* bench/mipsFrontEndBench.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsFrontEndBench;
	// consumed instructions of all tests and cycle budgets
	localparam int TOTAL_INSTR = 20 + 16 + 24 + 19 + 9 + 14;
	localparam int CYCLES_PER_INSTR = 60;
	localparam int SETUP_CYCLES = 50;
	localparam int NUM_TESTS = 6;

	logic clk;
	logic rst;
	mipsPkg::word_t wbAdr;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	mipsPkg::word_t wbDatIn;
	logic wbAck;
	logic execReady;
	logic decValid;
	mipsPkg::word_t decPcPlus4;
	mipsPkg::word_t decSrcA;
	mipsPkg::word_t decSrcB;
	mipsPkg::word_t decImm;
	mipsPkg::regAddr_t decDest;
	mipsPkg::aluFunc_t decAluFunc;
	logic decRegWrite;
	logic decMemRead;
	logic decMemWrite;
	logic decLink;
	logic decReserved;
	logic wbEn;
	mipsPkg::regAddr_t wbAddr;
	mipsPkg::word_t wbData;
	logic [1:0] waitCycles;

	mipsPkg::word_t seed = 32'hbcca_a066;
	int errorCount = 0;
	// reference state
	mipsPkg::word_t progWords [0:255];
	mipsPkg::word_t regModel [0:31];
	mipsPkg::word_t expPc;
	mipsPkg::word_t savedTarget;
	logic armed;
	// bus protocol tracking between samples
	logic prevReq;
	logic prevAck;
	mipsPkg::word_t prevAdr;

	mipsFrontEnd UUT (
		.clk(clk), .rst(rst),
		.wbAdr(wbAdr), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbDatIn(wbDatIn), .wbAck(wbAck),
		.execReady(execReady), .decValid(decValid), .decPcPlus4(decPcPlus4),
		.decSrcA(decSrcA), .decSrcB(decSrcB), .decImm(decImm), .decDest(decDest),
		.decAluFunc(decAluFunc), .decRegWrite(decRegWrite), .decMemRead(decMemRead),
		.decMemWrite(decMemWrite), .decLink(decLink), .decReserved(decReserved),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
	);

	instrMemory imem (
		.clk(clk), .rst(rst), .adr(wbAdr), .cyc(wbCyc), .stb(wbStb), .we(wbWe),
		.datOut(wbDatIn), .ack(wbAck), .waitCycles(waitCycles)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic mipsPkg::word_t nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic mipsPkg::word_t encR(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [4:0] sh);
		return {`OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic mipsPkg::word_t encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			mipsPkg::halfword_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mipsPkg::word_t encJ(logic [5:0] op, mipsPkg::word_t target);
		return {op, target[27:2]};
	endfunction

	task automatic abortRun();
		$display("tests failed");
		$fatal(1, "stopping at first error");
	endtask

	initial begin
		#((TOTAL_INSTR * CYCLES_PER_INSTR + NUM_TESTS * SETUP_CYCLES) * 40);
		$display("watchdog expired before the tests finished");
		abortRun();
	end

	task automatic checkValue(input string testName, input string field,
			input mipsPkg::word_t expected, input mipsPkg::word_t actual);
		assert (expected === actual) else begin
			errorCount++;
			$display("Error %s: %s expected %h actual %h", testName, field, expected, actual);
			abortRun();
		end
	endtask

	// every address gets its own ADDIU word
	task automatic clearProgram();
		mipsPkg::word_t a;
		for (int i = 0; i < 256; i++) begin
			a = `RESET_PC + 32'(i * 4);
			progWords[i] = encI(`OP_ADDIU, 5'd0, 5'd9, a[15:0] ^ a[31:16]);
		end
	endtask

	task automatic resetDut();
		rst = 1'b1;
		execReady = 1'b0;
		wbEn = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		assert (!wbCyc && !wbStb && !decValid) else begin
			$display("bus request or decode valid active during reset");
			abortRun();
		end
		rst = 1'b0;
	endtask

	// known values for branch and jump tests and random values elsewhere
	task automatic initRegs();
		mipsPkg::word_t v;
		regModel[0] = 32'd0;
		for (int i = 1; i < 32; i++) begin
			case (i)
				1: v = 32'd5;
				2: v = 32'd5;
				3: v = 32'd7;
				4: v = 32'hffff_fffd;
				5: v = `RESET_PC + 32'd96;
				default: v = nextRand();
			endcase
			@(posedge clk);
			#2;
			wbEn = 1'b1;
			wbAddr = i[4:0];
			wbData = v;
			regModel[i] = v;
		end
		@(posedge clk);
		#2;
		wbEn = 1'b0;
	endtask

	task automatic checkBus(input string testName);
		assert (!wbWe && wbCyc == wbStb) else begin
			$display("%s: write enable set or cyc and stb differ", testName);
			abortRun();
		end
		if (prevReq) begin
			assert (wbCyc && wbAdr == prevAdr) else begin
				$display("%s: request dropped or address moved before ack", testName);
				abortRun();
			end
		end
		if (prevAck) begin
			assert (!wbCyc) else begin
				$display("%s: cyc did not fall after ack", testName);
				abortRun();
			end
		end
		prevReq = wbCyc && !wbAck;
		prevAck = wbCyc && wbAck;
		prevAdr = wbAdr;
	endtask

	task automatic checkConsumed(input string testName);
		mipsPkg::word_t instr, rsVal, rtVal, extImm, target, pcPlus4;
		logic [5:0] op, fn;
		logic [4:0] rs, rt, rd, expDest;
		logic [3:0] expAlu;
		logic expRw, expMr, expMw, expLink, expRes;
		logic zext, useImm, destRt, taken, jumpOp, jrOp;
		instr = progWords[expPc[9:2]];
		op = instr[31:26];
		fn = instr[5:0];
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		expAlu = `ALU_ADD;
		{expRw, expMr, expMw, expLink, expRes} = 5'b0;
		{zext, useImm, destRt, taken, jumpOp, jrOp} = 6'b0;
		case (op)
			`OP_RTYPE: begin
				expRw = 1'b1;
				case (fn)
					`FN_ADDU: expAlu = `ALU_ADD;
					`FN_SUBU: expAlu = `ALU_SUB;
					`FN_AND: expAlu = `ALU_AND;
					`FN_OR: expAlu = `ALU_OR;
					`FN_XOR: expAlu = `ALU_XOR;
					`FN_SLT: expAlu = `ALU_SLT;
					`FN_SLL: expAlu = `ALU_SLL;
					`FN_SRL: expAlu = `ALU_SRL;
					`FN_JR: begin
						expRw = 1'b0;
						jrOp = 1'b1;
					end
					default: begin
						expRw = 1'b0;
						expRes = 1'b1;
					end
				endcase
			end
			`OP_ADDIU, `OP_SLTI, `OP_LUI: begin
				{expRw, useImm, destRt} = 3'b111;
				expAlu = (op == `OP_SLTI) ? `ALU_SLT : ((op == `OP_LUI) ? `ALU_LUI : `ALU_ADD);
			end
			`OP_ANDI, `OP_ORI, `OP_XORI: begin
				{expRw, useImm, destRt, zext} = 4'b1111;
				expAlu = (op == `OP_ANDI) ? `ALU_AND : ((op == `OP_ORI) ? `ALU_OR : `ALU_XOR);
			end
			`OP_LW: {expRw, destRt, expMr} = 3'b111;
			`OP_SW: expMw = 1'b1;
			`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ: ;
			`OP_J: jumpOp = 1'b1;
			`OP_JAL: {jumpOp, expLink, expRw} = 3'b111;
			default: expRes = 1'b1;
		endcase
		extImm = zext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
		// writeback in this very cycle must be visible
		rsVal = (wbEn && wbAddr != 5'd0 && wbAddr == rs) ? wbData : regModel[rs];
		rtVal = (wbEn && wbAddr != 5'd0 && wbAddr == rt) ? wbData : regModel[rt];
		case (op)
			`OP_BEQ: taken = (rsVal == rtVal);
			`OP_BNE: taken = (rsVal != rtVal);
			`OP_BLEZ: taken = ($signed(rsVal) <= 32'sd0);
			`OP_BGTZ: taken = ($signed(rsVal) > 32'sd0);
			default: taken = 1'b0;
		endcase
		pcPlus4 = expPc + 32'd4;
		if (jrOp)
			target = rsVal;
		else if (jumpOp)
			target = {pcPlus4[31:28], instr[25:0], 2'b00};
		else
			target = pcPlus4 + {extImm[29:0], 2'b00};
		expDest = expLink ? `LINK_REG : (destRt ? rt : rd);

		checkValue(testName, "pcPlus4", pcPlus4, decPcPlus4);
		checkValue(testName, "aluFunc", {28'd0, expAlu}, {28'd0, decAluFunc});
		checkValue(testName, "regWrite", {31'd0, expRw}, {31'd0, decRegWrite});
		checkValue(testName, "memRead", {31'd0, expMr}, {31'd0, decMemRead});
		checkValue(testName, "memWrite", {31'd0, expMw}, {31'd0, decMemWrite});
		checkValue(testName, "link", {31'd0, expLink}, {31'd0, decLink});
		checkValue(testName, "reserved", {31'd0, expRes}, {31'd0, decReserved});
		checkValue(testName, "imm", extImm, decImm);
		checkValue(testName, "srcA", rsVal, decSrcA);
		checkValue(testName, "srcB", useImm ? extImm : rtVal, decSrcB);
		if (expRw)
			checkValue(testName, "dest", {27'd0, expDest}, {27'd0, decDest});

		// delay slot issues before the saved target
		if (armed) begin
			expPc = savedTarget;
			armed = 1'b0;
		end else begin
			expPc = pcPlus4;
		end
		if (taken || jumpOp || jrOp) begin
			armed = 1'b1;
			savedTarget = target;
		end
	endtask

	task automatic runProgram(input string testName, input int count, input logic stall,
			input logic randomWb);
		mipsPkg::word_t r;
		mipsPkg::word_t nextInstr;
		int consumed;
		consumed = 0;
		resetDut();
		for (int i = 0; i < 256; i++)
			imem.prog[i] = progWords[i];
		initRegs();
		expPc = `RESET_PC;
		armed = 1'b0;
		prevReq = 1'b0;
		prevAck = 1'b0;
		while (consumed < count) begin
			@(posedge clk);
			#2;
			r = nextRand();
			nextInstr = progWords[expPc[9:2]];
			waitCycles = r[1:0];
			execReady = stall ? (r[3:2] != 2'b00) : 1'b1;
			wbEn = randomWb && r[4];
			case (r[6:5])
				2'b00: wbAddr = 5'd0;
				// aim at the sources of the instruction expected in decode
				2'b01: wbAddr = nextInstr[25:21];
				2'b10: wbAddr = nextInstr[20:16];
				default: wbAddr = 5'd8 + {1'b0, r[10:7]};
			endcase
			wbData = nextRand();
			@(negedge clk);
			checkBus(testName);
			if (decValid && execReady) begin
				checkConsumed(testName);
				consumed++;
			end
			if (wbEn && wbAddr != 5'd0)
				regModel[wbAddr] = wbData;
		end
		@(posedge clk);
		#2;
		execReady = 1'b0;
		wbEn = 1'b0;
	endtask

	task automatic testSequential();
		clearProgram();
		runProgram("sequential", 20, 1'b0, 1'b0);
	endtask

	task automatic testControlDecode();
		clearProgram();
		progWords[0] = encR(`FN_ADDU, 5'd8, 5'd9, 5'd16, 5'd0);
		progWords[1] = encR(`FN_SUBU, 5'd10, 5'd11, 5'd17, 5'd0);
		progWords[2] = encR(`FN_AND, 5'd12, 5'd13, 5'd18, 5'd0);
		progWords[3] = encR(`FN_OR, 5'd14, 5'd15, 5'd19, 5'd0);
		progWords[4] = encR(`FN_XOR, 5'd16, 5'd17, 5'd20, 5'd0);
		progWords[5] = encR(`FN_SLT, 5'd18, 5'd19, 5'd21, 5'd0);
		progWords[6] = encR(`FN_SLL, 5'd0, 5'd9, 5'd22, 5'd3);
		progWords[7] = encR(`FN_SRL, 5'd0, 5'd10, 5'd23, 5'd17);
		progWords[8] = encI(`OP_ADDIU, 5'd8, 5'd18, 16'h8001);
		progWords[9] = encI(`OP_SLTI, 5'd9, 5'd19, 16'hfff0);
		progWords[10] = encI(`OP_ANDI, 5'd10, 5'd20, 16'h8f0f);
		progWords[11] = encI(`OP_ORI, 5'd11, 5'd21, 16'hffff);
		progWords[12] = encI(`OP_XORI, 5'd12, 5'd22, 16'h1234);
		progWords[13] = encI(`OP_LUI, 5'd0, 5'd23, 16'habcd);
		progWords[14] = encI(`OP_LW, 5'd8, 5'd24, 16'h0010);
		progWords[15] = encI(`OP_SW, 5'd8, 5'd9, 16'hfffc);
		runProgram("control decode", 16, 1'b0, 1'b0);
	endtask

	task automatic testRegisterBypass();
		mipsPkg::word_t r;
		logic [5:0] fn;
		clearProgram();
		for (int i = 0; i < 24; i++) begin
			r = nextRand();
			case (r[12:11])
				2'd0: fn = `FN_ADDU;
				2'd1: fn = `FN_SUBU;
				2'd2: fn = `FN_XOR;
				default: fn = `FN_SLT;
			endcase
			// sources in 8..15 or r0 and results in 16..23
			progWords[i] = encR(fn, (r[1:0] == 2'b00) ? 5'd0 : {2'b01, r[4:2]},
				{2'b01, r[7:5]}, {2'b10, r[10:8]}, 5'd0);
		end
		runProgram("register bypass", 24, 1'b0, 1'b1);
	endtask

	task automatic testBranches();
		clearProgram();
		progWords[0] = encI(`OP_BEQ, 5'd1, 5'd2, 16'd9);
		progWords[10] = encI(`OP_BEQ, 5'd1, 5'd3, 16'd5);
		progWords[12] = encI(`OP_BNE, 5'd1, 5'd3, 16'd7);
		progWords[20] = encI(`OP_BNE, 5'd1, 5'd2, 16'd3);
		progWords[22] = encI(`OP_BLEZ, 5'd4, 5'd0, 16'd7);
		progWords[30] = encI(`OP_BLEZ, 5'd3, 5'd0, 16'd5);
		progWords[32] = encI(`OP_BGTZ, 5'd3, 5'd0, 16'd7);
		progWords[40] = encI(`OP_BGTZ, 5'd4, 5'd0, 16'd5);
		// backward branch to index 2
		progWords[42] = encI(`OP_BEQ, 5'd0, 5'd0, 16'hffd7);
		runProgram("branches", 19, 1'b1, 1'b0);
	endtask

	task automatic testJumps();
		clearProgram();
		progWords[0] = encJ(`OP_J, `RESET_PC + 32'd32);
		progWords[8] = encJ(`OP_JAL, `RESET_PC + 32'd64);
		// r5 points at index 24
		progWords[16] = encR(`FN_JR, 5'd5, 5'd0, 5'd0, 5'd0);
		runProgram("jumps", 9, 1'b1, 1'b0);
	endtask

	task automatic testReservedStall();
		clearProgram();
		progWords[0] = encR(`FN_ADDU, 5'd1, 5'd2, 5'd8, 5'd0);
		progWords[1] = encI(6'h01, 5'd1, 5'd2, 16'h0004);
		progWords[2] = encI(6'h20, 5'd1, 5'd9, 16'h0008);
		progWords[3] = encR(6'h18, 5'd1, 5'd2, 5'd0, 5'd0);
		progWords[4] = encR(6'h0c, 5'd0, 5'd0, 5'd0, 5'd0);
		progWords[5] = encI(6'h3f, 5'd3, 5'd10, 16'hffff);
		progWords[6] = encI(`OP_BNE, 5'd1, 5'd3, 16'd5);
		progWords[7] = encI(`OP_ORI, 5'd0, 5'd11, 16'h00ff);
		runProgram("reserved and stall", 14, 1'b1, 1'b0);
	endtask

	initial begin
		rst = 1'b1;
		execReady = 1'b0;
		wbEn = 1'b0;
		wbAddr = 5'd0;
		wbData = 32'd0;
		waitCycles = 2'd0;
		prevReq = 1'b0;
		prevAck = 1'b0;
		prevAdr = 32'd0;
		armed = 1'b0;
		testSequential();
		testControlDecode();
		testRegisterBypass();
		testBranches();
		testJumps();
		testReservedStall();
		if (errorCount == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			abortRun();
		end
	end
endmodule

/* mipsFrontEnd.f */
+incdir+verilog
verilog/mipsPkg.sv
verilog/pipeIntf.sv
verilog/fetchUnit.sv
verilog/mainDecoder.sv
verilog/decode.sv
verilog/regFile.sv
verilog/mipsFrontEnd.sv
bench/instrMemory.sv
bench/mipsFrontEndBench.sv

/* verilog/decode.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module decode (
	fetchDecodeIntf.decode fd,
	pcSelectIntf.decode pcSel,
	regFileIntf.decode rf,
	input logic execReady,
	input logic wbEn,
	input mipsPkg::regAddr_t wbAddr,
	input mipsPkg::word_t wbData,
	output logic decValid,
	output mipsPkg::word_t decPcPlus4,
	output mipsPkg::word_t decSrcA,
	output mipsPkg::word_t decSrcB,
	output mipsPkg::word_t decImm,
	output mipsPkg::regAddr_t decDest,
	output mipsPkg::aluFunc_t decAluFunc,
	output logic decRegWrite,
	output logic decMemRead,
	output logic decMemWrite,
	output logic decLink,
	output logic decReserved
);
	mipsPkg::regAddr_t rs;
	mipsPkg::regAddr_t rt;
	mipsPkg::regAddr_t rd;
	mipsPkg::halfword_t imm;
	mipsPkg::word_t extImm;
	mipsPkg::word_t rsVal;
	mipsPkg::word_t rtVal;
	mipsPkg::word_t branchTarget;
	mipsPkg::word_t jumpTarget;
	mipsPkg::branchType_t branchType;
	logic branchTaken;
	logic zeroExt;
	logic useImm;
	logic destIsRt;
	logic jump;
	logic jr;

	assign rs = fd.instr[25:21];
	assign rt = fd.instr[20:16];
	assign rd = fd.instr[15:11];
	assign imm = fd.instr[15:0];

	mainDecoder ctrl (
		.instr(fd.instr),
		.aluFunc(decAluFunc),
		.branchType(branchType),
		.zeroExt(zeroExt),
		.useImm(useImm),
		.regWrite(decRegWrite),
		.destIsRt(destIsRt),
		.memRead(decMemRead),
		.memWrite(decMemWrite),
		.jump(jump),
		.jr(jr),
		.link(decLink),
		.reserved(decReserved)
	);

	assign extImm = zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	// register reads, a writeback in this cycle wins over the array
	assign rf.ra1 = rs;
	assign rf.ra2 = rt;
	assign rsVal = (wbEn && wbAddr != 5'd0 && wbAddr == rs) ? wbData : rf.rd1;
	assign rtVal = (wbEn && wbAddr != 5'd0 && wbAddr == rt) ? wbData : rf.rd2;

	always_comb begin
		case (branchType)
			`BR_EQ: branchTaken = (rsVal == rtVal);
			`BR_NE: branchTaken = (rsVal != rtVal);
			`BR_LEZ: branchTaken = rsVal[31] || (rsVal == 32'd0);
			`BR_GTZ: branchTaken = !rsVal[31] && (rsVal != 32'd0);
			default: branchTaken = 1'b0;
		endcase
	end

	assign branchTarget = fd.pcPlus4 + {extImm[29:0], 2'b00};
	assign jumpTarget = {fd.pcPlus4[31:28], fd.instr[25:0], 2'b00};

	// only while the instruction actually leaves decode
	assign pcSel.redirect = fd.valid && execReady && (branchTaken || jump || jr);
	assign pcSel.target = jr ? rsVal : (jump ? jumpTarget : branchTarget);

	assign fd.execReady = execReady;

	assign decValid = fd.valid;
	assign decPcPlus4 = fd.pcPlus4;
	assign decSrcA = rsVal;
	// SW keeps the store data here
	assign decSrcB = useImm ? extImm : rtVal;
	assign decImm = extImm;
	assign decDest = decLink ? `LINK_REG : (destIsRt ? rt : rd);
endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module fetchUnit (
	input logic clk,
	input logic rst,
	output mipsPkg::word_t wbAdr,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	input mipsPkg::word_t wbDatIn,
	input logic wbAck,
	fetchDecodeIntf.fetch fd,
	pcSelectIntf.fetch pcSel
);
	mipsPkg::fetchState_t state;
	// address of the next request
	mipsPkg::word_t pc;
	mipsPkg::word_t pcPlus4;
	mipsPkg::word_t pcNext;
	// fetched word waiting for decode
	mipsPkg::word_t skidInstr;
	mipsPkg::word_t skidPcPlus4;
	// redirect seen while the delay slot is still on the bus
	mipsPkg::word_t pendTarget;
	logic pendValid;
	// fetch/decode register
	mipsPkg::word_t fdInstr;
	mipsPkg::word_t fdPcPlus4;
	logic fdValid;
	logic fdFree;

	assign pcPlus4 = pc + 32'd4;
	// decode either holds nothing or hands its instruction on this edge
	assign fdFree = !fdValid || fd.execReady;

	// address following the fetch that completes now
	always_comb begin
		if (pcSel.redirect)
			pcNext = pcSel.target;
		else if (pendValid)
			pcNext = pendTarget;
		else
			pcNext = pcPlus4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mipsPkg::FETCH_IDLE;
			pc <= `RESET_PC;
			pendValid <= 1'b0;
			fdValid <= 1'b0;
		end else begin
			case (state)
				mipsPkg::FETCH_IDLE: begin
					state <= mipsPkg::FETCH_REQUEST;
				end
				mipsPkg::FETCH_REQUEST: begin
					if (wbAck) begin
						state <= mipsPkg::FETCH_HOLD;
						pc <= pcNext;
						pendValid <= 1'b0;
					end else if (pcSel.redirect) begin
						pendValid <= 1'b1;
					end
				end
				mipsPkg::FETCH_HOLD: begin
					if (fdFree) begin
						state <= mipsPkg::FETCH_REQUEST;
						// delay slot already fetched, so jump right away
						if (pcSel.redirect)
							pc <= pcSel.target;
					end
				end
				default: begin
					state <= mipsPkg::FETCH_IDLE;
				end
			endcase

			if (state == mipsPkg::FETCH_HOLD && fdFree)
				fdValid <= 1'b1;
			else if (fd.execReady)
				fdValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == mipsPkg::FETCH_REQUEST && wbAck) begin
			skidInstr <= wbDatIn;
			skidPcPlus4 <= pcPlus4;
		end
		if (state == mipsPkg::FETCH_REQUEST && !wbAck && pcSel.redirect)
			pendTarget <= pcSel.target;
		if (state == mipsPkg::FETCH_HOLD && fdFree) begin
			fdInstr <= skidInstr;
			fdPcPlus4 <= skidPcPlus4;
		end
	end

	// read-only classic cycle, address stays put until ack
	assign wbAdr = pc;
	assign wbCyc = (state == mipsPkg::FETCH_REQUEST);
	assign wbStb = (state == mipsPkg::FETCH_REQUEST);
	assign wbWe = 1'b0;

	assign fd.instr = fdInstr;
	assign fd.pcPlus4 = fdPcPlus4;
	assign fd.valid = fdValid;
endmodule

/* verilog/mainDecoder.sv */
`timescale 1ns/1ps
`include "mips_macros.svh"

module mainDecoder (
	input mipsPkg::word_t instr,
	output mipsPkg::aluFunc_t aluFunc,
	output mipsPkg::branchType_t branchType,
	output logic zeroExt,
	output logic useImm,
	output logic regWrite,
	output logic destIsRt,
	output logic memRead,
	output logic memWrite,
	output logic jump,
	output logic jr,
	output logic link,
	output logic reserved
);
	mipsPkg::op_t op;
	mipsPkg::func_t func;

	assign op = instr[31:26];
	assign func = instr[5:0];

	always_comb begin
		// defaults describe an instruction with no effect
		aluFunc = `ALU_ADD;
		branchType = `BR_NONE;
		zeroExt = 1'b0;
		useImm = 1'b0;
		regWrite = 1'b0;
		destIsRt = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		jump = 1'b0;
		jr = 1'b0;
		link = 1'b0;
		reserved = 1'b0;

		case (op)
			`OP_RTYPE: begin
				regWrite = 1'b1;
				case (func)
					`FN_ADDU: aluFunc = `ALU_ADD;
					`FN_SUBU: aluFunc = `ALU_SUB;
					`FN_AND: aluFunc = `ALU_AND;
					`FN_OR: aluFunc = `ALU_OR;
					`FN_XOR: aluFunc = `ALU_XOR;
					`FN_SLT: aluFunc = `ALU_SLT;
					// shift amount is taken from decImm[10:6]
					`FN_SLL: aluFunc = `ALU_SLL;
					`FN_SRL: aluFunc = `ALU_SRL;
					`FN_JR: begin
						regWrite = 1'b0;
						jr = 1'b1;
					end
					default: begin
						regWrite = 1'b0;
						reserved = 1'b1;
					end
				endcase
			end
			`OP_ADDIU, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				useImm = 1'b1;
				regWrite = 1'b1;
				destIsRt = 1'b1;
				zeroExt = (op == `OP_ANDI) || (op == `OP_ORI) || (op == `OP_XORI);
				case (op)
					`OP_SLTI: aluFunc = `ALU_SLT;
					`OP_ANDI: aluFunc = `ALU_AND;
					`OP_ORI: aluFunc = `ALU_OR;
					`OP_XORI: aluFunc = `ALU_XOR;
					`OP_LUI: aluFunc = `ALU_LUI;
					default: aluFunc = `ALU_ADD;
				endcase
			end
			// address is srcA plus decImm for both memory ops
			`OP_LW: begin
				regWrite = 1'b1;
				destIsRt = 1'b1;
				memRead = 1'b1;
			end
			`OP_SW: memWrite = 1'b1;
			`OP_BEQ: branchType = `BR_EQ;
			`OP_BNE: branchType = `BR_NE;
			`OP_BLEZ: branchType = `BR_LEZ;
			`OP_BGTZ: branchType = `BR_GTZ;
			`OP_J: jump = 1'b1;
			`OP_JAL: begin
				jump = 1'b1;
				link = 1'b1;
				regWrite = 1'b1;
			end
			default: reserved = 1'b1;
		endcase
	end
endmodule

/* verilog/mipsFrontEnd.sv */
`timescale 1ns/1ps

module mipsFrontEnd (
	input logic clk,
	input logic rst,
	// instruction bus, Wishbone classic master
	output mipsPkg::word_t wbAdr,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	input mipsPkg::word_t wbDatIn,
	input logic wbAck,
	// towards execute
	input logic execReady,
	output logic decValid,
	output mipsPkg::word_t decPcPlus4,
	output mipsPkg::word_t decSrcA,
	output mipsPkg::word_t decSrcB,
	output mipsPkg::word_t decImm,
	output mipsPkg::regAddr_t decDest,
	output mipsPkg::aluFunc_t decAluFunc,
	output logic decRegWrite,
	output logic decMemRead,
	output logic decMemWrite,
	output logic decLink,
	output logic decReserved,
	// writeback
	input logic wbEn,
	input mipsPkg::regAddr_t wbAddr,
	input mipsPkg::word_t wbData
);
	fetchDecodeIntf fdLink ();
	pcSelectIntf pcSelLink ();
	regFileIntf rfLink ();

	fetchUnit fetch (
		.clk(clk),
		.rst(rst),
		.wbAdr(wbAdr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.fd(fdLink.fetch),
		.pcSel(pcSelLink.fetch)
	);

	decode dec (
		.fd(fdLink.decode),
		.pcSel(pcSelLink.decode),
		.rf(rfLink.decode),
		.execReady(execReady),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.decValid(decValid),
		.decPcPlus4(decPcPlus4),
		.decSrcA(decSrcA),
		.decSrcB(decSrcB),
		.decImm(decImm),
		.decDest(decDest),
		.decAluFunc(decAluFunc),
		.decRegWrite(decRegWrite),
		.decMemRead(decMemRead),
		.decMemWrite(decMemWrite),
		.decLink(decLink),
		.decReserved(decReserved)
	);

	regFile regs (
		.clk(clk),
		.rf(rfLink.regfile),
		.wen(wbEn),
		.wa(wbAddr),
		.wd(wbData)
	);
endmodule

/* verilog/mipsPkg.sv */
package mipsPkg;

	// data and address words
	typedef logic [31:0] word_t;

	// immediate field as it sits in the instruction
	typedef logic [15:0] halfword_t;

	// register number, rs/rt/rd and writeback address
	typedef logic [4:0] regAddr_t;

	// instruction fields
	typedef logic [5:0] op_t;
	typedef logic [5:0] func_t;

	// execute operation, see ALU_* codes
	typedef logic [3:0] aluFunc_t;

	// none, eq, ne, lez, gtz
	typedef logic [2:0] branchType_t;

	// instruction fetch sequencing
	// idle only right after reset, request drives the bus,
	// hold keeps a fetched word until decode can take it
	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQUEST,
		FETCH_HOLD
	} fetchState_t;

endpackage

/* verilog/mips_macros.svh */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// first fetch address after reset, kseg1 boot vector
`define RESET_PC 32'hbfc0_0000

// return address register for JAL
`define LINK_REG 5'd31

// primary opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_BLEZ  6'h06
`define OP_BGTZ  6'h07
`define OP_ADDIU 6'h09
`define OP_SLTI  6'h0a
`define OP_ANDI  6'h0c
`define OP_ORI   6'h0d
`define OP_XORI  6'h0e
`define OP_LUI   6'h0f
`define OP_LW    6'h23
`define OP_SW    6'h2b

// function field of R-type instructions
`define FN_SLL  6'h00
`define FN_SRL  6'h02
`define FN_JR   6'h08
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

// operation codes handed to execute
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR  4'd3
`define ALU_XOR 4'd4
`define ALU_SLT 4'd5
`define ALU_SLL 4'd6
`define ALU_SRL 4'd7
`define ALU_LUI 4'd8

// branch conditions
`define BR_NONE 3'd0
`define BR_EQ   3'd1
`define BR_NE   3'd2
`define BR_LEZ  3'd3
`define BR_GTZ  3'd4

`endif

/* verilog/pipeIntf.sv */
`timescale 1ns/1ps

// fetch/decode pipeline register towards decode
interface fetchDecodeIntf;
	mipsPkg::word_t instr;
	mipsPkg::word_t pcPlus4;
	logic valid;
	// decode side accepts the instruction
	logic execReady;

	modport fetch (
		output instr,
		output pcPlus4,
		output valid,
		input execReady
	);

	modport decode (
		input instr,
		input pcPlus4,
		input valid,
		output execReady
	);
endinterface

// branch and jump redirect back to fetch
interface pcSelectIntf;
	logic redirect;
	mipsPkg::word_t target;

	modport decode (
		output redirect,
		output target
	);

	modport fetch (
		input redirect,
		input target
	);
endinterface

// register file read ports
interface regFileIntf;
	mipsPkg::regAddr_t ra1;
	mipsPkg::regAddr_t ra2;
	mipsPkg::word_t rd1;
	mipsPkg::word_t rd2;

	modport decode (
		output ra1,
		output ra2,
		input rd1,
		input rd2
	);

	modport regfile (
		input ra1,
		input ra2,
		output rd1,
		output rd2
	);
endinterface

/* verilog/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic clk,
	regFileIntf.regfile rf,
	input logic wen,
	input mipsPkg::regAddr_t wa,
	input mipsPkg::word_t wd
);
	mipsPkg::word_t regs [0:31];

	// register 0 is never written
	always_ff @(posedge clk) begin
		if (wen && wa != 5'd0)
			regs[wa] <= wd;
	end

	// asynchronous reads, zero register forced here
	assign rf.rd1 = (rf.ra1 == 5'd0) ? 32'd0 : regs[rf.ra1];
	assign rf.rd2 = (rf.ra2 == 5'd0) ? 32'd0 : regs[rf.ra2];
endmodule
